// File: project.f
src/fpu_pkg.sv
src/fpu_register_stack.sv
src/fpu_stack_sequencer.sv
src/fpu_status_control.sv
src/fpu_stack_unit.sv
testbench/fpu_stack_tb.sv

// File: Makefile
# Verilator flow for the FPU register stack subsystem

VERILATOR  ?= verilator
TOP        ?= fpu_stack_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

# Static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: testbench/fpu_stack_tb.sv
`timescale 1ns/1ps

module fpu_stack_tb
    import fpu_pkg::*;
();

    localparam int NUM_REGS = 8;

    typedef enum {K_LOAD, K_STORE, K_XCHG, K_FREE, K_INC, K_DEC, K_CW, K_CLR} row_kind_e;
    typedef enum {CLS_ZERO, CLS_SPECIAL, CLS_VALID} data_class_e;
    typedef enum {F_NONE, F_OVER, F_UNDER} fault_e;

    // One stimulus row with its expected tag and fault
    typedef struct {
        row_kind_e           kind;
        logic [2:0]          idx;
        logic [FP_WIDTH-1:0] value;
        fpu_tag_e            tag;
        fault_e              fault;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  op_strobe;
    fpu_op_e               op_code;
    logic [2:0]            op_index;
    logic [FP_WIDTH-1:0]   op_data;
    logic                  cw_write;
    logic [15:0]           cw_data;
    logic                  sw_clear;
    logic                  busy;
    logic                  result_valid;
    logic [FP_WIDTH-1:0]   result_data;
    logic [FP_WIDTH-1:0]   st0;
    logic [2*NUM_REGS-1:0] tag_word;
    logic [15:0]           status_word;
    logic [15:0]           control_word;
    logic                  fpu_irq;

    // ==================================================
    // Reference model state
    // ==================================================

    logic [FP_WIDTH-1:0] m_regs [NUM_REGS];
    fpu_tag_e            m_tags [NUM_REGS];
    bit                  m_known [NUM_REGS];
    logic [2:0]          m_top;
    logic                m_ie;
    logic                m_sf;
    logic                m_c1;
    logic [15:0]         m_cw;

    row_t        rows [$];
    logic [31:0] rng = 32'h7f0e;
    int          row_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycles = 0;
    int          cycle_limit = 100;

    fpu_stack_unit #(
        .NUM_REGS (NUM_REGS)
    ) fpu_stack_unit_i (
        .clk          (clk),
        .reset        (reset),
        .op_strobe    (op_strobe),
        .op_code      (op_code),
        .op_index     (op_index),
        .op_data      (op_data),
        .cw_write     (cw_write),
        .cw_data      (cw_data),
        .sw_clear     (sw_clear),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data),
        .st0          (st0),
        .tag_word     (tag_word),
        .status_word  (status_word),
        .control_word (control_word),
        .fpu_irq      (fpu_irq)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ==================================================
    // Stimulus generation
    // ==================================================

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Random value bent into the requested class
    function automatic logic [FP_WIDTH-1:0] make_value(input data_class_e cls);
        logic [FP_WIDTH-1:0] v;
        logic [31:0]         hi;
        logic [31:0]         mid;
        logic [31:0]         lo;
        logic [14:0]         e;
        hi  = rand_word();
        mid = rand_word();
        lo  = rand_word();
        v   = {hi[15:0], mid, lo};
        e   = v[FP_EXP_MSB:FP_EXP_LSB];
        case (cls)
            // Sign survives
            CLS_ZERO: v[FP_EXP_MSB:0] = '0;
            CLS_SPECIAL: begin
                if (hi[31]) begin
                    // Infinity or NaN
                    v[FP_EXP_MSB:FP_EXP_LSB] = '1;
                end else begin
                    // Denormal
                    v[FP_EXP_MSB:FP_EXP_LSB] = '0;
                    v[0] = 1'b1;
                end
            end
            default: begin
                if ((e == '0) || (&e)) begin
                    v[FP_EXP_MSB:FP_EXP_LSB] = 15'h3FFF;
                end
            end
        endcase
        return v;
    endfunction

    function automatic fpu_tag_e tag_of_class(input data_class_e cls);
        case (cls)
            CLS_ZERO:    return TAG_ZERO;
            CLS_SPECIAL: return TAG_SPECIAL;
            default:     return TAG_VALID;
        endcase
    endfunction

    function automatic fpu_op_e opcode_of(input row_kind_e kind);
        case (kind)
            K_STORE: return OP_STORE_POP;
            K_XCHG:  return OP_EXCHANGE;
            K_FREE:  return OP_FREE;
            K_INC:   return OP_INC_PTR;
            K_DEC:   return OP_DEC_PTR;
            default: return OP_LOAD;
        endcase
    endfunction

    task automatic add_op(input row_kind_e kind, input logic [2:0] idx,
                          input logic [FP_WIDTH-1:0] value, input fault_e fault);
        row_t r;
        r.kind  = kind;
        r.idx   = idx;
        r.value = value;
        r.tag   = TAG_EMPTY;
        r.fault = fault;
        rows.push_back(r);
    endtask

    task automatic add_load(input data_class_e cls, input fault_e fault);
        row_t r;
        r.kind  = K_LOAD;
        r.idx   = 3'd0;
        r.value = make_value(cls);
        r.tag   = tag_of_class(cls);
        r.fault = fault;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Fill all eight slots with every class
        add_load(CLS_ZERO, F_NONE);
        add_load(CLS_SPECIAL, F_NONE);
        add_load(CLS_VALID, F_NONE);
        add_load(CLS_VALID, F_NONE);
        add_load(CLS_ZERO, F_NONE);
        add_load(CLS_SPECIAL, F_NONE);
        add_load(CLS_VALID, F_NONE);
        add_load(CLS_VALID, F_NONE);
        // Ninth load lands on an occupied slot
        add_load(CLS_VALID, F_OVER);
        add_op(K_CLR, 3'd0, '0, F_NONE);
        add_op(K_XCHG, 3'd2, '0, F_NONE);
        // Tenth load overflows again and sets C1
        add_load(CLS_VALID, F_OVER);
        // Drain in LIFO order
        for (int i = 0; i < NUM_REGS; i++) begin
            add_op(K_STORE, 3'd0, '0, F_NONE);
        end
        // Masked underflow clears C1
        add_op(K_STORE, 3'd0, '0, F_UNDER);
        add_op(K_CLR, 3'd0, '0, F_NONE);
        // Unmask invalid operation, then pop the empty stack
        add_op(K_CW, 3'd0, 80'(16'h037E), F_NONE);
        add_op(K_STORE, 3'd0, '0, F_UNDER);
        add_op(K_CLR, 3'd0, '0, F_NONE);
        // Free and pointer rotation
        add_load(CLS_VALID, F_NONE);
        add_load(CLS_SPECIAL, F_NONE);
        add_op(K_FREE, 3'd1, '0, F_NONE);
        add_op(K_INC, 3'd0, '0, F_NONE);
        add_op(K_DEC, 3'd0, '0, F_NONE);
        add_op(K_DEC, 3'd0, '0, F_NONE);
        add_op(K_INC, 3'd0, '0, F_NONE);
        add_op(K_STORE, 3'd0, '0, F_NONE);
    endtask

    // ==================================================
    // Expected values and checks
    // ==================================================

    function automatic logic [2*NUM_REGS-1:0] expected_tags();
        logic [2*NUM_REGS-1:0] w;
        for (int i = 0; i < NUM_REGS; i++) begin
            w[2*i +: 2] = m_tags[m_top + 3'(i)];
        end
        return w;
    endfunction

    function automatic logic [15:0] expected_status();
        logic [15:0] s;
        s                  = '0;
        s[SW_IE]           = m_ie;
        s[SW_SF]           = m_sf;
        s[SW_ES]           = m_ie && !m_cw[CW_IM];
        s[SW_C1]           = m_c1;
        s[SW_TOP_LSB +: 3] = m_top;
        return s;
    endfunction

    task automatic check_equal(input string what, input logic [FP_WIDTH-1:0] got,
                               input logic [FP_WIDTH-1:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            row_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (row_errors == 0) begin
            tests_passed++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", num, name, row_errors);
        end
    endtask

    // Drive one row, step the model, check both result cycles
    task automatic apply_row(input row_t r, input int num);
        fault_e              fault;
        logic [FP_WIDTH-1:0] exp_result;
        logic [FP_WIDTH-1:0] tmp_data;
        fpu_tag_e            tmp_tag;
        bit                  tmp_known;
        bit                  res_known;
        logic [2:0]          slot;
        fault      = F_NONE;
        exp_result = '0;
        res_known  = 1'b0;
        row_errors = 0;
        @(posedge clk);
        case (r.kind)
            K_CW: begin
                cw_write <= 1'b1;
                cw_data  <= r.value[15:0];
            end
            K_CLR: sw_clear <= 1'b1;
            default: begin
                op_strobe <= 1'b1;
                op_code   <= opcode_of(r.kind);
                op_index  <= r.idx;
                op_data   <= r.value;
            end
        endcase
        // Sampling edge
        @(posedge clk);
        op_strobe <= 1'b0;
        cw_write  <= 1'b0;
        sw_clear  <= 1'b0;
        case (r.kind)
            K_LOAD: begin
                m_top = m_top - 3'd1;
                if (m_tags[m_top] != TAG_EMPTY) begin
                    fault = F_OVER;
                end
                m_regs[m_top]  = r.value;
                m_known[m_top] = 1'b1;
                m_tags[m_top]  = r.tag;
            end
            K_STORE: begin
                exp_result = m_regs[m_top];
                res_known  = m_known[m_top];
                if (m_tags[m_top] == TAG_EMPTY) begin
                    fault = F_UNDER;
                end
                m_tags[m_top] = TAG_EMPTY;
                m_top = m_top + 3'd1;
            end
            K_XCHG: begin
                slot            = m_top + r.idx;
                tmp_data        = m_regs[slot];
                tmp_tag         = m_tags[slot];
                tmp_known       = m_known[slot];
                m_regs[slot]    = m_regs[m_top];
                m_tags[slot]    = m_tags[m_top];
                m_known[slot]   = m_known[m_top];
                m_regs[m_top]   = tmp_data;
                m_tags[m_top]   = tmp_tag;
                m_known[m_top]  = tmp_known;
            end
            K_FREE: begin
                slot         = m_top + r.idx;
                m_tags[slot] = TAG_EMPTY;
            end
            K_INC: m_top = m_top + 3'd1;
            K_DEC: m_top = m_top - 3'd1;
            K_CW:  m_cw = r.value[15:0];
            default: begin
                m_ie = 1'b0;
                m_sf = 1'b0;
                m_c1 = 1'b0;
            end
        endcase
        if (fault != F_NONE) begin
            m_ie = 1'b1;
            m_sf = 1'b1;
            m_c1 = (fault == F_OVER);
        end
        assert (fault == r.fault) else begin
            $display("Stimulus table and model disagree on the stack fault of test %0d", num);
            row_errors++;
        end
        // Cycle after the sampling edge
        @(negedge clk);
        check_equal("busy", 80'(busy), 80'(r.kind == K_XCHG));
        check_equal("result_valid", 80'(result_valid), 80'(r.kind == K_STORE));
        if ((r.kind == K_STORE) && res_known) begin
            check_equal("result_data", result_data, exp_result);
        end
        // Everything settled one edge later
        @(posedge clk);
        @(negedge clk);
        check_equal("busy", 80'(busy), '0);
        check_equal("result_valid", 80'(result_valid), '0);
        if (m_known[m_top]) begin
            check_equal("st0", st0, m_regs[m_top]);
        end
        check_equal("tag_word", 80'(tag_word), 80'(expected_tags()));
        check_equal("status_word", 80'(status_word), 80'(expected_status()));
        check_equal("control_word", 80'(control_word), 80'(m_cw));
        check_equal("fpu_irq", 80'(fpu_irq), 80'(m_ie && !m_cw[CW_IM]));
        report_test(num, r.kind.name());
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        reset     <= 1'b1;
        op_strobe <= 1'b0;
        op_code   <= OP_LOAD;
        op_index  <= 3'd0;
        op_data   <= '0;
        cw_write  <= 1'b0;
        cw_data   <= '0;
        sw_clear  <= 1'b0;
        build_table();
        cycle_limit = rows.size() * 4 + 100;
        for (int i = 0; i < NUM_REGS; i++) begin
            m_tags[i]  = TAG_EMPTY;
            m_known[i] = 1'b0;
            m_regs[i]  = '0;
        end
        m_top = 3'd0;
        m_ie  = 1'b0;
        m_sf  = 1'b0;
        m_c1  = 1'b0;
        m_cw  = CW_RESET;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // State straight after reset
        @(negedge clk);
        row_errors = 0;
        check_equal("tag_word", 80'(tag_word), 80'(16'hFFFF));
        check_equal("status_word", 80'(status_word), '0);
        check_equal("control_word", 80'(control_word), 80'(CW_RESET));
        check_equal("busy", 80'(busy), '0);
        check_equal("result_valid", 80'(result_valid), '0);
        check_equal("fpu_irq", 80'(fpu_irq), '0);
        report_test(0, "RESET");
        foreach (rows[i]) begin
            apply_row(rows[i], i + 1);
        end
        @(posedge clk);
        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src/fpu_stack_unit.sv
`timescale 1ns/1ps

module fpu_stack_unit
    import fpu_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    // Instruction strobe
    input  logic                  op_strobe,
    input  fpu_op_e               op_code,
    input  logic [2:0]            op_index,
    input  logic [FP_WIDTH-1:0]   op_data,
    // Control and status access
    input  logic                  cw_write,
    input  logic [15:0]           cw_data,
    input  logic                  sw_clear,
    // Outputs
    output logic                  busy,
    output logic                  result_valid,
    output logic [FP_WIDTH-1:0]   result_data,
    output logic [FP_WIDTH-1:0]   st0,
    output logic [2*NUM_REGS-1:0] tag_word,
    output logic [15:0]           status_word,
    output logic [15:0]           control_word,
    output logic                  fpu_irq
);

    // Sequencer to stack
    logic                push;
    logic                pop;
    logic                write_enable;
    logic [2:0]          write_reg;
    logic [FP_WIDTH-1:0] write_data;
    logic                free_enable;
    logic [2:0]          free_reg;
    logic                ptr_inc;
    logic                ptr_dec;
    logic [2:0]          read_sel;
    logic [FP_WIDTH-1:0] read_data;
    // Stack to status block
    logic                stack_overflow;
    logic                stack_underflow;
    logic [2:0]          stack_ptr;

    fpu_stack_sequencer fpu_stack_sequencer_i (
        .clk          (clk),
        .reset        (reset),
        .op_strobe    (op_strobe),
        .op_code      (op_code),
        .op_index     (op_index),
        .op_data      (op_data),
        .st0          (st0),
        .read_data    (read_data),
        .push         (push),
        .pop          (pop),
        .write_enable (write_enable),
        .write_reg    (write_reg),
        .write_data   (write_data),
        .free_enable  (free_enable),
        .free_reg     (free_reg),
        .ptr_inc      (ptr_inc),
        .ptr_dec      (ptr_dec),
        .read_sel     (read_sel),
        .busy         (busy),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    fpu_register_stack #(
        .NUM_REGS (NUM_REGS)
    ) fpu_register_stack_i (
        .clk             (clk),
        .reset           (reset),
        .push            (push),
        .pop             (pop),
        .ptr_inc         (ptr_inc),
        .ptr_dec         (ptr_dec),
        .write_enable    (write_enable),
        .write_reg       (write_reg),
        .write_data      (write_data),
        .free_enable     (free_enable),
        .free_reg        (free_reg),
        .read_sel        (read_sel),
        .st0             (st0),
        .read_data       (read_data),
        .stack_ptr       (stack_ptr),
        .tag_word        (tag_word),
        .stack_overflow  (stack_overflow),
        .stack_underflow (stack_underflow)
    );

    fpu_status_control #(
        .NUM_REGS (NUM_REGS)
    ) fpu_status_control_i (
        .clk             (clk),
        .reset           (reset),
        .stack_overflow  (stack_overflow),
        .stack_underflow (stack_underflow),
        .stack_ptr       (stack_ptr),
        .cw_write        (cw_write),
        .cw_data         (cw_data),
        .sw_clear        (sw_clear),
        .status_word     (status_word),
        .control_word    (control_word),
        .fpu_irq         (fpu_irq)
    );

endmodule

// File: src/fpu_status_control.sv
`timescale 1ns/1ps

module fpu_status_control
    import fpu_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic        clk,
    input  logic        reset,
    // Fault pulses and pointer from the stack
    input  logic        stack_overflow,
    input  logic        stack_underflow,
    input  logic [2:0]  stack_ptr,
    // Control word load
    input  logic        cw_write,
    input  logic [15:0] cw_data,
    // FCLEX-like flag clear
    input  logic        sw_clear,
    output logic [15:0] status_word,
    output logic [15:0] control_word,
    output logic        fpu_irq
);

    localparam int PTR_W = $clog2(NUM_REGS);

    logic       ie;
    logic       sf;
    logic       c1;
    logic       es;
    logic [2:0] top_q;
    logic       fault;

    assign fault = stack_overflow || stack_underflow;

    // ==================================================
    // Sticky flags and TOP mirror
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ie    <= 1'b0;
            sf    <= 1'b0;
            c1    <= 1'b0;
            top_q <= 3'd0;
        end else begin
            // Only the live pointer bits
            top_q <= 3'(stack_ptr[PTR_W-1:0]);
            if (fault) begin
                // Fault beats a clear in the same cycle
                ie <= 1'b1;
                sf <= 1'b1;
                // C1 tells overflow from underflow
                c1 <= stack_overflow;
            end else if (sw_clear) begin
                ie <= 1'b0;
                sf <= 1'b0;
                c1 <= 1'b0;
            end
        end
    end

    // Control word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            control_word <= CW_RESET;
        end else if (cw_write) begin
            control_word <= cw_data;
        end
    end

    // ==================================================
    // Status word assembly and interrupt
    // ==================================================

    // Unmasked invalid operation
    assign es = ie && !control_word[CW_IM];

    always_comb begin
        status_word                        = '0;
        status_word[SW_IE]                 = ie;
        status_word[SW_SF]                 = sf;
        status_word[SW_ES]                 = es;
        status_word[SW_C1]                 = c1;
        status_word[SW_TOP_LSB +: 3]       = top_q;
    end

    assign fpu_irq = status_word[SW_ES];

    // A single stack move cannot fault both ways
    assert property (@(posedge clk) disable iff (reset)
        !(stack_overflow && stack_underflow));

endmodule

// File: src/fpu_stack_sequencer.sv
`timescale 1ns/1ps

module fpu_stack_sequencer
    import fpu_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    // Instruction strobe
    input  logic                op_strobe,
    input  fpu_op_e             op_code,
    input  logic [2:0]          op_index,
    input  logic [FP_WIDTH-1:0] op_data,
    // Stack read back
    input  logic [FP_WIDTH-1:0] st0,
    input  logic [FP_WIDTH-1:0] read_data,
    // Stack controls
    output logic                push,
    output logic                pop,
    output logic                write_enable,
    output logic [2:0]          write_reg,
    output logic [FP_WIDTH-1:0] write_data,
    output logic                free_enable,
    output logic [2:0]          free_reg,
    output logic                ptr_inc,
    output logic                ptr_dec,
    output logic [2:0]          read_sel,
    // Results
    output logic                busy,
    output logic                result_valid,
    output logic [FP_WIDTH-1:0] result_data
);

    // Second half of an exchange pending
    logic                xchg_phase;
    // Old ST(i) held for the write into ST(0)
    logic [FP_WIDTH-1:0] xchg_data;
    logic                start;

    assign start = op_strobe && !xchg_phase;
    assign busy  = xchg_phase;

    // ==================================================
    // Decode into stack controls
    // ==================================================

    always_comb begin
        push         = 1'b0;
        pop          = 1'b0;
        write_enable = 1'b0;
        write_reg    = 3'd0;
        write_data   = st0;
        free_enable  = 1'b0;
        free_reg     = op_index;
        ptr_inc      = 1'b0;
        ptr_dec      = 1'b0;
        read_sel     = op_index;
        if (xchg_phase) begin
            // Latched ST(i) into ST(0)
            write_enable = 1'b1;
            write_data   = xchg_data;
        end else if (op_strobe) begin
            case (op_code)
                OP_LOAD: begin
                    push         = 1'b1;
                    write_enable = 1'b1;
                    write_data   = op_data;
                end
                OP_STORE_POP: pop = 1'b1;
                OP_EXCHANGE: begin
                    // Old ST(0) into ST(i)
                    write_enable = 1'b1;
                    write_reg    = op_index;
                end
                OP_FREE:    free_enable = 1'b1;
                OP_INC_PTR: ptr_inc     = 1'b1;
                OP_DEC_PTR: ptr_dec     = 1'b1;
                default: ;
            endcase
        end
    end

    // ==================================================
    // Exchange phase and result pulse
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            xchg_phase   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            xchg_phase   <= start && (op_code == OP_EXCHANGE);
            result_valid <= start && (op_code == OP_STORE_POP);
        end
    end

    always_ff @(posedge clk) begin
        if (start && (op_code == OP_STORE_POP)) begin
            result_data <= st0;
        end
        if (start && (op_code == OP_EXCHANGE)) begin
            xchg_data <= read_data;
        end
    end

    // No new instruction during the exchange
    assert property (@(posedge clk) disable iff (reset)
        !(op_strobe && busy));

    // One result pulse for each pop sent to the stack
    assert property (@(posedge clk) disable iff (reset)
        result_valid == $past(pop));

endmodule

// File: src/fpu_register_stack.sv
`timescale 1ns/1ps

module fpu_register_stack
    import fpu_pkg::*;
#(
    parameter int NUM_REGS = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    // Stack moves, at most one per cycle
    input  logic                    push,
    input  logic                    pop,
    input  logic                    ptr_inc,
    input  logic                    ptr_dec,
    // Write of a logical register
    input  logic                    write_enable,
    input  logic [2:0]              write_reg,
    input  logic [FP_WIDTH-1:0]     write_data,
    // Tag release
    input  logic                    free_enable,
    input  logic [2:0]              free_reg,
    // Reads
    input  logic [2:0]              read_sel,
    output logic [FP_WIDTH-1:0]     st0,
    output logic [FP_WIDTH-1:0]     read_data,
    output logic [2:0]              stack_ptr,
    output logic [2*NUM_REGS-1:0]   tag_word,
    // Fault pulses
    output logic                    stack_overflow,
    output logic                    stack_underflow
);

    localparam int PTR_W = $clog2(NUM_REGS);

    // Physical index must fit the 3-bit logical ports
    if ((NUM_REGS < 2) || (NUM_REGS > 8) || ((NUM_REGS & (NUM_REGS - 1)) != 0))
    begin : g_num_regs_check
        $error("NUM_REGS must be a power of two from 2 to 8");
    end

    // ==================================================
    // Storage
    // ==================================================

    logic [FP_WIDTH-1:0] regs [NUM_REGS];
    fpu_tag_e            tags [NUM_REGS];
    logic [PTR_W-1:0]    top;
    logic [PTR_W-1:0]    next_top;
    logic [PTR_W-1:0]    wr_phys;

    // Logical to physical, wraps modulo NUM_REGS
    function automatic logic [PTR_W-1:0] phys(input logic [PTR_W-1:0] base,
                                              input logic [2:0]       lreg);
        return base + lreg[PTR_W-1:0];
    endfunction

    // Pointer after this cycle's move
    always_comb begin
        next_top = top;
        if (push || ptr_dec) begin
            next_top = top - 1'b1;
        end else if (pop || ptr_inc) begin
            next_top = top + 1'b1;
        end
    end

    // Push writes land on the new top
    assign wr_phys = push ? phys(next_top, write_reg) : phys(top, write_reg);

    // ==================================================
    // Pointer, tags and fault flags
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top             <= '0;
            stack_overflow  <= 1'b0;
            stack_underflow <= 1'b0;
            for (int i = 0; i < NUM_REGS; i++) begin
                tags[i] <= TAG_EMPTY;
            end
        end else begin
            // Slot about to become ST(0) still occupied
            stack_overflow  <= push && (tags[next_top] != TAG_EMPTY);
            // Nothing on top to pop
            stack_underflow <= pop && (tags[top] == TAG_EMPTY);
            top <= next_top;
            if (pop) begin
                tags[top] <= TAG_EMPTY;
            end
            if (free_enable) begin
                tags[phys(top, free_reg)] <= TAG_EMPTY;
            end
            // Last so a write wins over a release of the same slot
            if (write_enable) begin
                tags[wr_phys] <= classify_tag(write_data);
            end
        end
    end

    // Register contents
    always_ff @(posedge clk) begin
        if (write_enable) begin
            regs[wr_phys] <= write_data;
        end
    end

    // ==================================================
    // Combinational views
    // ==================================================

    assign st0       = regs[top];
    assign read_data = regs[phys(top, read_sel)];
    assign stack_ptr = 3'(top);

    // ST(0) in the low two bits
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            tag_word[2*i +: 2] = tags[phys(top, 3'(i))];
        end
    end

    // Sequencer issues a single pointer move per cycle
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({push, pop, ptr_inc, ptr_dec}));

    // Overflow exactly when a push meets an occupied last logical slot
    assert property (@(posedge clk) disable iff (reset)
        stack_overflow == $past(push && (tag_word[2*NUM_REGS-2 +: 2] != TAG_EMPTY)));
    // Underflow exactly when a pop meets an empty ST(0)
    assert property (@(posedge clk) disable iff (reset)
        stack_underflow == $past(pop && (tag_word[1:0] == TAG_EMPTY)));

endmodule

// File: src/fpu_pkg.sv
package fpu_pkg;

    // ==================================================
    // Extended-precision register layout
    // ==================================================

    // Sign, 15-bit exponent, 64-bit mantissa
    localparam int FP_WIDTH   = 80;
    localparam int FP_EXP_MSB = 78;
    localparam int FP_EXP_LSB = 64;

    // Two-bit tag per stack register
    typedef enum logic [1:0] {
        TAG_VALID   = 2'b00,
        TAG_ZERO    = 2'b01,
        TAG_SPECIAL = 2'b10,  // NaN, infinity or denormal
        TAG_EMPTY   = 2'b11
    } fpu_tag_e;

    // Stack opcodes, codes 6 and 7 do nothing
    typedef enum logic [2:0] {
        OP_LOAD      = 3'd0,
        OP_STORE_POP = 3'd1,
        OP_EXCHANGE  = 3'd2,
        OP_FREE      = 3'd3,
        OP_INC_PTR   = 3'd4,
        OP_DEC_PTR   = 3'd5
    } fpu_op_e;

    // ==================================================
    // Status and control word bit positions
    // ==================================================

    localparam int SW_IE      = 0;   // Invalid operation
    localparam int SW_SF      = 6;   // Stack fault
    localparam int SW_ES      = 7;   // Error summary
    localparam int SW_C1      = 9;
    localparam int SW_TOP_LSB = 11;  // TOP in bits 13..11

    localparam int          CW_IM    = 0;  // Invalid-operation mask
    localparam logic [15:0] CW_RESET = 16'h037F;

    // Tag of an 80-bit value
    function automatic fpu_tag_e classify_tag(input logic [FP_WIDTH-1:0] value);
        logic [FP_EXP_MSB-FP_EXP_LSB:0] exponent;
        logic [FP_EXP_LSB-1:0]          mantissa;
        exponent = value[FP_EXP_MSB:FP_EXP_LSB];
        mantissa = value[FP_EXP_LSB-1:0];
        if ((exponent == '0) && (mantissa == '0)) begin
            return TAG_ZERO;
        end else if (&exponent) begin
            // Infinity or NaN
            return TAG_SPECIAL;
        end else if (exponent == '0) begin
            // Denormal
            return TAG_SPECIAL;
        end
        return TAG_VALID;
    endfunction

endpackage
